// File: logic/mcast_macros.svh
`ifndef MCAST_MACROS_SVH
`define MCAST_MACROS_SVH

// width of a request address, of a rule address and of every mask
`define MCAST_ADDR_W 32

// tile coordinate width, held in the top bits of an address
`define MCAST_COORD_W 4

// width of the payload that rides along with each request
`define MCAST_PAYLOAD_W 16

// number of programmable rules in the address map, default rule not counted
`define MCAST_NO_RULES 4

// number of target indices, the last one belongs to the default target
`define MCAST_NO_IDX 5

// width of a target index as carried in rules and beats
`define MCAST_IDX_W 3

// index reserved for the default target
`define MCAST_DEFAULT_IDX 4

// replication coefficient counts up to MCAST_NO_RULES remote matches
`define MCAST_REP_W 3

`endif

// File: logic/mcast_pkg.sv
`include "mcast_macros.svh"

package mcast_pkg;

  // split view of an address, coordinate of the owning tile on top
  typedef struct packed {
    logic [`MCAST_COORD_W-1:0]               coord;
    logic [`MCAST_ADDR_W-`MCAST_COORD_W-1:0] offset;
  } mcast_addr_fields_t;

  // the same address word, matched as raw bits or split to read the tile coordinate
  typedef union packed {
    logic [`MCAST_ADDR_W-1:0] raw;
    mcast_addr_fields_t       fld;
  } mcast_addr_u;

  // one entry of the address map, a set 1 in mask makes that address bit a don't care
  typedef struct packed {
    logic [`MCAST_IDX_W-1:0]  idx;
    mcast_addr_u              addr;
    logic [`MCAST_ADDR_W-1:0] mask;
  } mcast_rule_t;

  // incoming request, an address set in {addr, mask} form plus its source tile
  typedef struct packed {
    mcast_addr_u                 addr;
    logic [`MCAST_ADDR_W-1:0]    mask;
    logic [`MCAST_COORD_W-1:0]   src_coord;
    logic [`MCAST_PAYLOAD_W-1:0] payload;
  } mcast_req_t;

  // decoder result with one subset slot per target index
  typedef struct packed {
    logic [`MCAST_NO_IDX-1:0]                        select;
    logic [`MCAST_NO_IDX-1:0][`MCAST_ADDR_W-1:0]     sub_addr;
    logic [`MCAST_NO_IDX-1:0][`MCAST_ADDR_W-1:0]     sub_mask;
    logic [`MCAST_REP_W-1:0]                         rep_coeff;
    logic                                            error;
  } mcast_dec_t;

  // one output beat towards a single target
  typedef struct packed {
    logic [`MCAST_IDX_W-1:0]     idx;
    logic [`MCAST_ADDR_W-1:0]    addr;
    logic [`MCAST_ADDR_W-1:0]    mask;
    logic [`MCAST_PAYLOAD_W-1:0] payload;
    logic [`MCAST_REP_W-1:0]     rep_coeff;
    logic                        last;
  } mcast_beat_t;

endpackage

// File: logic/addr_map_regs.sv
`include "mcast_macros.svh"

module addr_map_regs import mcast_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 cfg_we_i,
  input  logic [2:0]                           cfg_slot_i,
  input  mcast_rule_t                          cfg_rule_i,
  output mcast_rule_t [`MCAST_NO_RULES-1:0]    rules_o,
  output mcast_rule_t                          default_rule_o
);

  // the four programmable rules
  mcast_rule_t [`MCAST_NO_RULES-1:0] rules_q;

  // the default rule describes the union of all other rules
  // a request bit masked here but not in the request keeps the default target out
  mcast_rule_t default_q;

  // slot decode, 0 to 3 pick a rule and 4 picks the default rule
  logic rule_hit;
  logic default_hit;

  assign rule_hit    = cfg_we_i && (cfg_slot_i < 3'(`MCAST_NO_RULES));
  assign default_hit = cfg_we_i && (cfg_slot_i == 3'(`MCAST_NO_RULES));

  // the map comes out of reset as all zero rules pointing at index 0
  // a write lands on the edge where the strobe is high, so a request
  // decoded in that same cycle still sees the previous contents
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rules_q   <= '0;
      default_q <= '0;
    end else begin
      if (rule_hit) begin
        rules_q[cfg_slot_i[1:0]] <= cfg_rule_i;
      end
      if (default_hit) begin
        default_q <= cfg_rule_i;
      end
      // slots 5 to 7 fall through untouched
    end
  end

  // no read-back path, the decoder is the only consumer
  assign rules_o        = rules_q;
  assign default_rule_o = default_q;

endmodule

// File: logic/multiaddr_decode.sv
`include "mcast_macros.svh"

module multiaddr_decode import mcast_pkg::*; (
  input  mcast_req_t                          req_i,
  input  mcast_rule_t [`MCAST_NO_RULES-1:0]   rules_i,
  input  mcast_rule_t                         default_rule_i,
  input  logic                                default_en_i,
  output mcast_dec_t                          dec_o
);

  // per rule match flags and coordinate comparison
  logic [`MCAST_NO_RULES-1:0] rule_match;
  logic [`MCAST_NO_RULES-1:0] rule_remote;
  logic                       any_match;

  // request bits that are masked but not covered by the default rule's mask
  logic [`MCAST_ADDR_W-1:0]   uncovered;

  // every rule is checked in parallel
  // a bit is a don't care when masked in the request or in the rule,
  // all other bits must agree for the two address sets to overlap
  always_comb begin
    for (int i = 0; i < `MCAST_NO_RULES; i++) begin
      rule_match[i]  = &((req_i.mask | rules_i[i].mask) |
                         ~(req_i.addr.raw ^ rules_i[i].addr.raw));
      // the rule's own tile sits in the top bits of its address
      rule_remote[i] = (rules_i[i].addr.fld.coord != req_i.src_coord);
    end
  end

  assign any_match = |rule_match;
  assign uncovered = req_i.mask & ~default_rule_i.mask;

  always_comb begin
    dec_o = '0;
    for (int i = 0; i < `MCAST_NO_RULES; i++) begin
      if (rule_match[i]) begin
        // each remote target costs one extra copy in the network
        dec_o.rep_coeff = dec_o.rep_coeff + `MCAST_REP_W'(rule_remote[i]);
        // an index outside the target range selects nothing
        if (rules_i[i].idx < `MCAST_IDX_W'(`MCAST_NO_IDX)) begin
          dec_o.select[rules_i[i].idx] = 1'b1;
          // bits masked only in the request resolve to the rule's value,
          // bits masked in both stay masked in the subset
          dec_o.sub_mask[rules_i[i].idx] = req_i.mask & rules_i[i].mask;
          dec_o.sub_addr[rules_i[i].idx] = (~req_i.mask & req_i.addr.raw) |
                                           (req_i.mask & rules_i[i].addr.raw);
        end
      end
    end

    // the default target catches what the rules leave over,
    // either nothing matched or part of the set lies outside the rule union
    if (default_en_i && (!any_match || (|uncovered))) begin
      dec_o.select[`MCAST_DEFAULT_IDX]   = 1'b1;
      dec_o.sub_addr[`MCAST_DEFAULT_IDX] = req_i.addr.raw;
      dec_o.sub_mask[`MCAST_DEFAULT_IDX] = req_i.mask;
    end

    // with the default mapping on there is always somewhere to go
    dec_o.error = !default_en_i && !any_match;
  end

endmodule

// File: logic/mcast_issue_buf.sv
`include "mcast_macros.svh"

module mcast_issue_buf import mcast_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         load_i,
  input  logic                         advance_i,
  input  mcast_dec_t                   dec_i,
  input  logic [`MCAST_PAYLOAD_W-1:0]  payload_i,
  output logic                         empty_o,
  output mcast_beat_t                  beat_o
);

  // targets still waiting for their beat
  logic [`MCAST_NO_IDX-1:0] pend_q;

  // captured subsets, one slot per target index
  logic [`MCAST_NO_IDX-1:0][`MCAST_ADDR_W-1:0] addr_q;
  logic [`MCAST_NO_IDX-1:0][`MCAST_ADDR_W-1:0] mask_q;
  logic [`MCAST_REP_W-1:0]                     coeff_q;
  logic [`MCAST_PAYLOAD_W-1:0]                 payload_q;

  // lowest pending target, as index and as one-hot
  logic [`MCAST_IDX_W-1:0]  head_idx;
  logic [`MCAST_NO_IDX-1:0] head_onehot;
  logic [`MCAST_NO_IDX-1:0] pend_rest;

  // the pending set is the only control state here
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else if (load_i) begin
      pend_q <= dec_i.select;
    end else if (advance_i) begin
      pend_q <= pend_rest;
    end
  end

  // subsets, coefficient and payload of the multicast being issued
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      addr_q    <= dec_i.sub_addr;
      mask_q    <= dec_i.sub_mask;
      coeff_q   <= dec_i.rep_coeff;
      payload_q <= payload_i;
    end
  end

  // isolate the lowest set bit, two's complement trick
  assign head_onehot = pend_q & (~pend_q + 1'b1);
  assign pend_rest   = pend_q & ~head_onehot;

  // scan downwards so the lowest pending index wins
  always_comb begin
    head_idx = '0;
    for (int i = `MCAST_NO_IDX - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        head_idx = `MCAST_IDX_W'(i);
      end
    end
  end

  assign empty_o = ~|pend_q;

  // the head beat is always on display, the controller decides when it is valid
  always_comb begin
    beat_o.idx       = head_idx;
    beat_o.addr      = addr_q[head_idx];
    beat_o.mask      = mask_q[head_idx];
    beat_o.payload   = payload_q;
    beat_o.rep_coeff = coeff_q;
    // last once nothing else is left behind the head
    beat_o.last      = ~|pend_rest;
  end

endmodule

// File: logic/mcast_ctrl.sv
module mcast_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic req_valid_i,
  input  logic dec_error_i,
  input  logic empty_i,
  output logic load_o,
  output logic advance_o,
  output logic busy_o,
  output logic out_valid_o,
  output logic dec_error_o
);

  // a request is taken only while no multicast is in flight
  logic accept;

  // one cycle error pulse following a failed decode
  logic err_q;

  assign accept = req_valid_i && empty_i;

  // good decodes go into the issue buffer at the accept edge,
  // failed ones load nothing and only raise the error pulse
  assign load_o = accept && !dec_error_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= accept && dec_error_i;
    end
  end

  assign dec_error_o = err_q;

  // without back-pressure every cycle with a pending target emits a beat
  // and retires it at the following edge
  assign out_valid_o = !empty_i;
  assign advance_o   = !empty_i;

  // busy spans exactly the beat cycles
  // requests arriving during them are dropped, not queued
  assign busy_o = !empty_i;

endmodule

// File: logic/mcast_router_top.sv
`include "mcast_macros.svh"

module mcast_router_top import mcast_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  // address map write port
  input  logic         cfg_we_i,
  input  logic [2:0]   cfg_slot_i,
  input  mcast_rule_t  cfg_rule_i,
  input  logic         default_en_i,
  // request side
  input  logic         req_valid_i,
  input  mcast_req_t   req_i,
  // beat side
  output logic         busy_o,
  output logic         out_valid_o,
  output mcast_beat_t  out_beat_o,
  output logic         dec_error_o
);

  // map contents towards the decoder
  mcast_rule_t [`MCAST_NO_RULES-1:0] map_rules;
  mcast_rule_t                       map_default;

  // decode of the request currently on req_i
  mcast_dec_t dec;

  // handshake between control and issue buffer
  logic buf_load;
  logic buf_advance;
  logic buf_empty;

  addr_map_regs i_addr_map_regs (
    .clk_i          ( clk_i       ),
    .rst_n_i        ( rst_n_i     ),
    .cfg_we_i       ( cfg_we_i    ),
    .cfg_slot_i     ( cfg_slot_i  ),
    .cfg_rule_i     ( cfg_rule_i  ),
    .rules_o        ( map_rules   ),
    .default_rule_o ( map_default )
  );

  // purely combinational, the request is sampled only when control loads it
  multiaddr_decode i_multiaddr_decode (
    .req_i          ( req_i        ),
    .rules_i        ( map_rules    ),
    .default_rule_i ( map_default  ),
    .default_en_i   ( default_en_i ),
    .dec_o          ( dec          )
  );

  mcast_issue_buf i_mcast_issue_buf (
    .clk_i     ( clk_i         ),
    .rst_n_i   ( rst_n_i       ),
    .load_i    ( buf_load      ),
    .advance_i ( buf_advance   ),
    .dec_i     ( dec           ),
    .payload_i ( req_i.payload ),
    .empty_o   ( buf_empty     ),
    .beat_o    ( out_beat_o    )
  );

  mcast_ctrl i_mcast_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .dec_error_i ( dec.error   ),
    .empty_i     ( buf_empty   ),
    .load_o      ( buf_load    ),
    .advance_o   ( buf_advance ),
    .busy_o      ( busy_o      ),
    .out_valid_o ( out_valid_o ),
    .dec_error_o ( dec_error_o )
  );

endmodule

// File: tb/tb_mcast_tests.svh
function automatic mcast_rule_t make_rule(input logic [2:0] idx, input logic [31:0] addr,
                                          input logic [31:0] mask);
  mcast_rule_t r;
  r.idx      = idx;
  r.addr.raw = addr;
  r.mask     = mask;
  return r;
endfunction

function automatic mcast_req_t make_req(input logic [31:0] addr, input logic [31:0] mask,
                                        input logic [3:0] src,
                                        input logic [`MCAST_PAYLOAD_W-1:0] payload);
  mcast_req_t r;
  r.addr.raw  = addr;
  r.mask      = mask;
  r.src_coord = src;
  r.payload   = payload;
  return r;
endfunction

// one slot write through the config port, mirrored into the model copy
task automatic write_rule(input logic [2:0] slot, input mcast_rule_t rule);
  @(posedge clk_i);
  cfg_we_i   <= 1'b1;
  cfg_slot_i <= slot;
  cfg_rule_i <= rule;
  @(posedge clk_i);
  cfg_we_i <= 1'b0;
  if (slot < 3'd4) begin
    model_rules[slot[1:0]] = rule;
  end else if (slot == 3'd4) begin
    model_default = rule;
  end
endtask

task automatic set_default(input logic en);
  @(posedge clk_i);
  default_en_i <= en;
  model_def_en = en;
endtask

// reference model of the decode rule, one beat per selected target in index order
// the tests keep rule indices unique and below 4, so each index has at most one rule
task automatic predict(input mcast_req_t req);
  logic [`MCAST_NO_IDX-1:0] sel;
  logic [31:0]              sub_addr [`MCAST_NO_IDX];
  logic [31:0]              sub_mask [`MCAST_NO_IDX];
  logic [31:0]              care;
  logic                     any;
  int                       coeff;
  int                       idx;
  mcast_beat_t              b;
  sel   = '0;
  any   = 1'b0;
  coeff = 0;
  exp_beats.delete();
  for (int i = 0; i < `MCAST_NO_RULES; i++) begin
    // only bits unmasked on both sides have to agree
    care = ~(req.mask | model_rules[i].mask);
    if (((req.addr.raw ^ model_rules[i].addr.raw) & care) == 32'h0) begin
      any = 1'b1;
      idx = int'(model_rules[i].idx);
      if (model_rules[i].addr.raw[31:28] != req.src_coord) begin
        coeff++;
      end
      sel[idx]      = 1'b1;
      sub_mask[idx] = req.mask & model_rules[i].mask;
      sub_addr[idx] = (req.addr.raw & ~req.mask) | (model_rules[i].addr.raw & req.mask);
    end
  end
  // the default target takes the whole request when something is left uncovered
  if (model_def_en && (!any || ((req.mask & ~model_default.mask) != 32'h0))) begin
    sel[4]      = 1'b1;
    sub_addr[4] = req.addr.raw;
    sub_mask[4] = req.mask;
  end
  exp_err = !model_def_en && !any;
  for (int i = 0; i < `MCAST_NO_IDX; i++) begin
    if (sel[i]) begin
      b.idx       = 3'(i);
      b.addr      = sub_addr[i];
      b.mask      = sub_mask[i];
      b.payload   = req.payload;
      b.rep_coeff = 3'(coeff);
      b.last      = ((sel >> (i + 1)) == '0);
      exp_beats.push_back(b);
    end
  end
endtask

// present one request for a single cycle once the router is idle
task automatic send_req(input mcast_req_t req);
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (busy_o && waited < TIMEOUT) begin
    @(negedge clk_i);
    waited++;
  end
  if (busy_o) begin
    stop_on_timeout("the router to go idle");
  end
  @(posedge clk_i);
  req_valid_i <= 1'b1;
  req_i       <= req;
  @(posedge clk_i);
  req_valid_i <= 1'b0;
endtask

// gather beats until last, or a single error pulse, sampled mid cycle
task automatic collect_resp(input string name);
  int   cycles;
  int   busy_cycles;
  logic done;
  got_beats.delete();
  got_err     = 1'b0;
  done        = 1'b0;
  cycles      = 0;
  busy_cycles = 0;
  while (!done && cycles < TIMEOUT) begin
    @(negedge clk_i);
    cycles++;
    if (busy_o) begin
      busy_cycles++;
    end
    if (dec_error_o) begin
      got_err = 1'b1;
      done    = 1'b1;
    end
    if (out_valid_o) begin
      got_beats.push_back(out_beat_o);
      done = done || out_beat_o.last;
    end else if (got_beats.size() > 0) begin
      proto_cnt++;
      $display("%s: gap between beats in cycle %0d", name, cycles);
    end
  end
  if (!done) begin
    stop_on_timeout({name, " response"});
  end
  if ((got_err && cycles != 1) || (!got_err && cycles != got_beats.size())) begin
    proto_cnt++;
    $display("%s: response did not start in the first cycle after accept", name);
  end
  if (busy_cycles != got_beats.size()) begin
    proto_cnt++;
    $display("%s: busy high for %0d cycles during %0d beats", name, busy_cycles,
             got_beats.size());
  end
  // the error is a single pulse and the beats stop after last
  @(negedge clk_i);
  if (busy_o || out_valid_o || dec_error_o) begin
    proto_cnt++;
    $display("%s: router did not return to idle after the response", name);
  end
endtask

task automatic compare_resp(input string name);
  int n;
  check_err(name, exp_err, got_err);
  if (got_beats.size() != exp_beats.size()) begin
    proto_cnt++;
    $display("%s: expected %0d beats but got %0d", name, exp_beats.size(), got_beats.size());
  end
  n = (got_beats.size() < exp_beats.size()) ? got_beats.size() : exp_beats.size();
  for (int i = 0; i < n; i++) begin
    check_beat(name, exp_beats[i], got_beats[i]);
  end
endtask

task automatic route(input string name, input mcast_req_t req);
  predict(req);
  send_req(req);
  collect_resp(name);
  compare_resp(name);
endtask

// four disjoint rules on tiles 1, 3, 4 and 7, default covering tiles 0 to 7
task automatic test_unicast();
  write_rule(3'd0, make_rule(3'd0, 32'h1000_0000, 32'h0000_00FF));
  write_rule(3'd1, make_rule(3'd1, 32'h3000_0000, 32'h0000_00FF));
  write_rule(3'd2, make_rule(3'd2, 32'h4000_0000, 32'h0000_00FF));
  write_rule(3'd3, make_rule(3'd3, 32'h7000_0000, 32'h0000_00FF));
  write_rule(3'd4, make_rule(3'd4, 32'h0000_0000, 32'h7000_00FF));
  route("unicast", make_req(32'h4000_0055, 32'h0, 4'h4, 16'hA001));
endtask

// tile bits 30:29 masked reach tiles 1, 3, 5 and 7, so rules 0, 1 and 3
task automatic test_multicast();
  route("multicast", make_req(32'h1000_0012, 32'h6000_000F, 4'h1, 16'hA002));
endtask

task automatic test_no_match();
  route("no_match", make_req(32'h9000_0000, 32'h0, 4'h2, 16'hA003));
endtask

// bit 31 is masked in the request but not in the default rule
task automatic test_default();
  set_default(1'b1);
  route("default", make_req(32'h3000_0001, 32'h8000_0000, 4'h3, 16'hA004));
endtask

// rule 1 moves from tile 3 to tile 5
task automatic test_reconfig();
  set_default(1'b0);
  write_rule(3'd1, make_rule(3'd1, 32'h5000_0000, 32'h0000_00FF));
  route("reconfig_new", make_req(32'h5000_0033, 32'h0, 4'h0, 16'hA005));
  route("reconfig_old", make_req(32'h3000_0033, 32'h0, 4'h0, 16'hA006));
endtask

task automatic test_random();
  logic [31:0] addr;
  logic [31:0] mask;
  for (int i = 0; i < RAND_COUNT; i++) begin
    addr = $random(seed) & 32'hF000_00FF;
    mask = $random(seed) & 32'hF000_000F;
    // every eighth request sets a middle bit that no rule covers
    if (i % 8 == 7) begin
      addr = addr | 32'h0010_0000;
    end
    set_default(i % 2 == 1);
    route($sformatf("random_%0d", i),
          make_req(addr, mask, 4'($random(seed)), `MCAST_PAYLOAD_W'($random(seed))));
  end
endtask

// File: tb/tb_mcast_router.sv
`include "mcast_macros.svh"

module tb_mcast_router import mcast_pkg::*; ();

  // wait limit in cycles and number of random requests
  localparam int TIMEOUT    = 50;
  localparam int RAND_COUNT = 40;

  // seed for every $random call in the tests
  int seed = 50;

  logic        clk_i;
  logic        rst_n_i;
  logic        cfg_we_i;
  logic [2:0]  cfg_slot_i;
  mcast_rule_t cfg_rule_i;
  logic        default_en_i;
  logic        req_valid_i;
  mcast_req_t  req_i;
  logic        busy_o;
  logic        out_valid_o;
  mcast_beat_t out_beat_o;
  logic        dec_error_o;

  // software copy of the map, updated alongside every config write
  mcast_rule_t model_rules [`MCAST_NO_RULES];
  mcast_rule_t model_default;
  logic        model_def_en;

  // predicted and observed response to the most recent request
  mcast_beat_t exp_beats [$];
  mcast_beat_t got_beats [$];
  logic        exp_err;
  logic        got_err;

  // wrong values and protocol problems are counted apart
  int mismatch_cnt = 0;
  int proto_cnt    = 0;

  mcast_router_top i_dut (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .cfg_we_i     ( cfg_we_i     ),
    .cfg_slot_i   ( cfg_slot_i   ),
    .cfg_rule_i   ( cfg_rule_i   ),
    .default_en_i ( default_en_i ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .busy_o       ( busy_o       ),
    .out_valid_o  ( out_valid_o  ),
    .out_beat_o   ( out_beat_o   ),
    .dec_error_o  ( dec_error_o  )
  );

  // period of 10 time units
  always #5 clk_i = ~clk_i;

  task automatic print_counts();
    $display("errors: %0d value mismatches, %0d protocol errors", mismatch_cnt, proto_cnt);
  endtask

  // a wait that never ends stops the whole run here
  task automatic stop_on_timeout(input string what);
    proto_cnt++;
    $display("timeout while waiting for %s", what);
    print_counts();
    $display("*** TEST FAILED ***");
    $fatal(1, "run aborted");
  endtask

  function automatic string beat_str(input mcast_beat_t b);
    return $sformatf("idx=%0d addr=%h mask=%h payload=%h coeff=%0d last=%b",
                     b.idx, b.addr, b.mask, b.payload, b.rep_coeff, b.last);
  endfunction

  task automatic check_beat(input string name, input mcast_beat_t exp, input mcast_beat_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, beat_str(exp), beat_str(act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("CHECK FAILED %s: expected error=%b, actual error=%b", name, exp, act);
    end
  endtask

  `include "tb_mcast_tests.svh"

  initial begin
    clk_i = 1'b0;
    rst_n_i      <= 1'b0;
    cfg_we_i     <= 1'b0;
    cfg_slot_i   <= '0;
    cfg_rule_i   <= '0;
    default_en_i <= 1'b0;
    req_valid_i  <= 1'b0;
    req_i        <= '0;
    // the map comes out of reset all zero, and so does its copy
    for (int i = 0; i < `MCAST_NO_RULES; i++) begin
      model_rules[i] = '0;
    end
    model_default = '0;
    model_def_en  = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_unicast();
    test_multicast();
    test_no_match();
    test_default();
    test_reconfig();
    test_random();

    print_counts();
    if (mismatch_cnt == 0 && proto_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
+incdir+tb
logic/mcast_pkg.sv
logic/addr_map_regs.sv
logic/multiaddr_decode.sv
logic/mcast_issue_buf.sv
logic/mcast_ctrl.sv
logic/mcast_router_top.sv
tb/tb_mcast_router.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the multicast router testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_mcast_router -o sim_mcast

# the log decides the result, the simulator exit status is not used
./obj_dir/sim_mcast | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
